//--- bench/clockGen.sv
//--------------------------------------------------
// Testbench clock and active-low reset, held for the
// first two rising edges.
//--------------------------------------------------
module clockGen #(
  parameter int period = 40
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;                                    // Released on the second edge
  end

endmodule

//--- bench/heapRefModel.svh
//--------------------------------------------------
// Reference model of the array heap, included inside
// the testbench. modelCommand returns the expected
// read data of one command and updates the model.
//--------------------------------------------------
`ifndef HEAP_REF_MODEL_SVH
`define HEAP_REF_MODEL_SVH

localparam int dataMask = (1 << `HEAP_DATA_BITS) - 1;

bit modelAllocated [`HEAP_ARRAYS];
int modelSize [`HEAP_ARRAYS];
int modelData [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];     // Survives Free and Clear like the store
int freeList [$];                                     // Latest freed array at the back
int nextNew;                                          // First array never handed out

function automatic void modelReset();
  freeList.delete();
  nextNew = 0;
  for (int a = 0; a < `HEAP_ARRAYS; a++) begin
    modelAllocated[a] = 1'b0;
    modelSize[a] = 0;
  end
endfunction

// Error code above the result word
function automatic int modelCommand(int op, int arr, int idx, int data);
  int err;
  int result;
  err = errNone;
  result = 0;
  if (op == opClear) begin
    modelReset();
  end else if (op == opAlloc) begin
    if (freeList.size() == 0 && nextNew == `HEAP_ARRAYS) begin
      err = errNoFreeArray;
    end else begin
      if (freeList.size() > 0) begin
        result = freeList.pop_back();                 // Reuse last freed first
      end else begin
        result = nextNew;
        nextNew++;
      end
      modelAllocated[result] = 1'b1;
      modelSize[result] = 0;
    end
  end else if (!(op inside {opWrite, opRead, opSize, opFree, opPush, opPop, opLess,
                            opAdd, opSubtract, opAnd, opOr, opXor})) begin
    err = errBadOperation;
  end else if (!modelAllocated[arr]) begin
    err = errNotAllocated;
  end else begin
    case (op)
      opWrite: begin
        modelData[arr][idx] = data;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
        result = data;
      end
      opSize: result = modelSize[arr];
      opFree: begin
        modelAllocated[arr] = 1'b0;
        freeList.push_back(arr);
      end
      opPush: begin
        if (modelSize[arr] == `HEAP_ARRAY_LENGTH) begin
          err = errArrayFull;
        end else begin
          modelData[arr][modelSize[arr]] = data;
          modelSize[arr]++;
          result = data;
        end
      end
      opPop: begin
        if (modelSize[arr] == 0) begin
          err = errArrayEmpty;
        end else begin
          modelSize[arr]--;
          result = modelData[arr][modelSize[arr]];
        end
      end
      opLess: begin
        for (int i = 0; i < modelSize[arr]; i++) begin
          if (modelData[arr][i] < data) result++;
        end
      end
      default: begin                                  // Read and element arithmetic
        if (idx >= modelSize[arr]) begin
          err = errOutOfBounds;
        end else begin
          case (op)
            opAdd:      result = modelData[arr][idx] + data;
            opSubtract: result = modelData[arr][idx] - data;
            opAnd:      result = modelData[arr][idx] & data;
            opOr:       result = modelData[arr][idx] | data;
            opXor:      result = modelData[arr][idx] ^ data;
            default:    result = modelData[arr][idx];
          endcase
          result = result & dataMask;                 // Wrap at 4096
          if (op != opRead) modelData[arr][idx] = result;
        end
      end
    endcase
  end
  return (err << `HEAP_DATA_BITS) | result;
endfunction

`endif

//--- bench/heapTb.sv
//--------------------------------------------------
// Testbench of the array heap. Random Wishbone commands
// are checked against the reference model, with one
// summary line per test and a closing count.
//--------------------------------------------------
`include "heapMemory_settings.svh"

module heapTb import heapStoragePkg::*, heapCommandPkg::*; ();

  typedef logic [`HEAP_OP_BITS-1:0] opCode;

  localparam int period    = 40;
  localparam int dataRange = 1 << `HEAP_DATA_BITS;
  // Preload, allocation, access, stack, arithmetic, counting, mixed
  localparam int commandTotal = 73 + 13 + 87 + 38 + 119 + 97 + 400;

  logic       clock;
  logic       reset;
  logic       cyc;
  logic       stb;
  logic       we;
  busAddress  adr;
  elementData datWrite;
  logic       ack;
  busReadData datRead;

  string testName;
  int    testCommands;
  int    testFailures;
  int    commandCount;
  int    failCount;
  heapOp opList [14] = '{opClear, opAlloc, opFree, opWrite, opRead, opSize, opPush,
                         opPop, opAdd, opSubtract, opAnd, opOr, opXor, opLess};

  `include "heapRefModel.svh"

  clockGen #(.period(period)) u_clock (.clock, .reset);

  heapMemory u_dut (.clock, .reset, .cyc, .stb, .we, .adr, .datWrite, .ack, .datRead);

  function automatic int randomBelow(int limit);
    return int'($urandom % limit);
  endfunction

  // One Wishbone write cycle, checked on its ack
  task automatic runCommand(input opCode op, input int arr, input int idx, input int data);
    int expected;
    int expectedWait;
    int waited;
    expectedWait = 2;                                 // Lookup, then respond
    if (op == opLess && modelAllocated[arr]) expectedWait += modelSize[arr];  // One scan each
    expected = modelCommand(op, arr, idx, data);
    @(posedge clock);
    cyc      <= 1'b1;
    stb      <= 1'b1;
    we       <= 1'b1;
    adr      <= {op, arrayNumber'(arr), elementIndex'(idx)};
    datWrite <= elementData'(data);
    waited = 0;
    @(negedge clock);
    while (!ack) begin                                // Sample between edges
      waited++;
      @(negedge clock);
    end
    testCommands++;
    assert (int'(datRead) == expected) else begin
      testFailures++;
      $display("FAILED %s: op %0d array %0d index %0d expected %h actual %h",
               testName, op, arr, idx, busReadData'(expected), datRead);
    end
    assert (waited == expectedWait) else begin
      testFailures++;
      $display("FAILED %s latency: op %0d expected %0d actual %0d",
               testName, op, expectedWait, waited);
    end
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
    @(negedge clock);
    assert (!ack) else begin
      testFailures++;
      $display("In %s the ack stayed high for more than one cycle", testName);
    end
  endtask

  task automatic startTest(input string name);
    testName     = name;
    testCommands = 0;
    testFailures = 0;
  endtask

  task automatic endTest();
    $display("%s: %0d commands, %0d failures", testName, testCommands, testFailures);
    commandCount += testCommands;
    failCount    += testFailures;
  endtask

  // Watchdog ----------------------------------------
  initial begin
    #(commandTotal * 12 * period);
    $display("Timeout: the heap stopped answering before all commands were done");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int    arr;
    int    idx;
    opCode op;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    datWrite     = '0;
    commandCount = 0;
    failCount    = 0;
    void'($urandom(82));
    modelReset();
    @(posedge reset);

    // Every element gets a known value before the tests
    startTest("preload");
    for (int a = 0; a < `HEAP_ARRAYS; a++) runCommand(opAlloc, 0, 0, 0);
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) runCommand(opWrite, a, i, randomBelow(dataRange));
    end
    runCommand(opClear, 0, 0, 0);
    endTest();

    startTest("allocation");
    for (int a = 0; a <= `HEAP_ARRAYS; a++) runCommand(opAlloc, 0, 0, 0);  // Ninth finds none
    runCommand(opFree, 5, 0, 0);
    runCommand(opFree, 2, 0, 0);
    runCommand(opAlloc, 0, 0, 0);
    runCommand(opAlloc, 0, 0, 0);
    endTest();

    startTest("element access");
    runCommand(opClear, 0, 0, 0);
    for (int a = 0; a < 6; a++) runCommand(opAlloc, 0, 0, 0);  // Arrays 6 and 7 stay free
    for (int n = 0; n < 80; n++) begin
      op = (randomBelow(2) == 0) ? opWrite : opRead;
      arr = randomBelow(`HEAP_ARRAYS);
      runCommand(op, arr, randomBelow(`HEAP_ARRAY_LENGTH), randomBelow(dataRange));
    end
    endTest();

    startTest("stack");
    runCommand(opClear, 0, 0, 0);
    runCommand(opAlloc, 0, 0, 0);
    for (int n = 0; n <= `HEAP_ARRAY_LENGTH; n++) begin   // Last Push hits a full array
      runCommand(opPush, 0, 0, randomBelow(dataRange));
      runCommand(opSize, 0, 0, 0);
    end
    for (int n = 0; n <= `HEAP_ARRAY_LENGTH; n++) begin   // Last Pop hits an empty array
      runCommand(opPop, 0, 0, 0);
      runCommand(opSize, 0, 0, 0);
    end
    endTest();

    startTest("element arithmetic");
    runCommand(opClear, 0, 0, 0);
    runCommand(opAlloc, 0, 0, 0);
    runCommand(opAlloc, 0, 0, 0);
    for (int a = 0; a < 2; a++) begin
      for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) runCommand(opWrite, a, i, randomBelow(dataRange));
    end
    for (int n = 0; n < 50; n++) begin
      op  = opList[8 + randomBelow(5)];               // Add through Xor
      arr = randomBelow(2);
      idx = randomBelow(`HEAP_ARRAY_LENGTH);
      runCommand(op, arr, idx, randomBelow(dataRange));
      runCommand(opRead, arr, idx, 0);
    end
    endTest();

    startTest("counting");
    runCommand(opClear, 0, 0, 0);
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      runCommand(opAlloc, 0, 0, 0);
      for (int n = randomBelow(`HEAP_ARRAY_LENGTH + 1); n > 0; n--) begin
        runCommand(opPush, a, 0, randomBelow(dataRange));
      end
      for (int n = 0; n < 3; n++) runCommand(opLess, a, 0, randomBelow(dataRange));
    end
    endTest();

    startTest("mixed random");
    for (int n = 0; n < 400; n++) begin
      case (randomBelow(16))
        0:       op = opCode'(randomBelow(1 << `HEAP_OP_BITS));  // Mostly unused codes
        1, 2, 3: op = opAlloc;
        default: op = opList[randomBelow(14)];
      endcase
      arr = randomBelow(`HEAP_ARRAYS);
      runCommand(op, arr, randomBelow(`HEAP_ARRAY_LENGTH), randomBelow(dataRange));
    end
    endTest();

    $display("Total: %0d commands, %0d failures", commandCount, failCount);
    if (failCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/arrayAllocator.sv
//--------------------------------------------------
// Array allocator. Freed arrays go on a stack and are
// reused last-in first-out before new ones are taken.
//--------------------------------------------------
`include "heapMemory_settings.svh"

module arrayAllocator import heapStoragePkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  arrayNumber array,
  input  logic       allocate,
  input  logic       releaseArray,
  input  logic       clearAll,
  output logic       allocated,
  output arrayNumber freeArray,
  output logic       noFreeArray
);

  logic [`HEAP_ARRAYS-1:0]   allocFlags;              // One bit per array
  arrayNumber                freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ARRAY_BITS:0] stackDepth;              // Freed arrays waiting
  logic [`HEAP_ARRAY_BITS:0] handedOut;               // High-water mark
  logic                      stackEmpty;

  assign stackEmpty  = stackDepth == '0;
  assign allocated   = allocFlags[array];
  assign freeArray   = stackEmpty ? arrayNumber'(handedOut)
                                  : freeStack[arrayNumber'(stackDepth - 1'b1)];
  assign noFreeArray = stackEmpty && handedOut[`HEAP_ARRAY_BITS];  // Top bit set: all used

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocFlags <= '0;
      stackDepth <= '0;
      handedOut  <= '0;
    end else if (clearAll) begin
      allocFlags <= '0;
      stackDepth <= '0;
      handedOut  <= '0;
    end else if (allocate) begin
      allocFlags[freeArray] <= 1'b1;
      if (stackEmpty) handedOut <= handedOut + 1'b1;
      else stackDepth <= stackDepth - 1'b1;           // Reuse the latest freed
    end else if (releaseArray) begin
      allocFlags[array] <= 1'b0;
      stackDepth        <= stackDepth + 1'b1;
    end
  end

  // Stack contents only matter below stackDepth
  always_ff @(posedge clock) begin
    if (releaseArray && !clearAll) freeStack[arrayNumber'(stackDepth)] <= array;
  end

endmodule

//--- rtl/arraySizeTable.sv
//--------------------------------------------------
// Live size of every array, with the bound, full and
// empty flags of the array being addressed.
//--------------------------------------------------
`include "heapMemory_settings.svh"

module arraySizeTable import heapStoragePkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  arrayNumber  array,
  input  logic        sizeSet,
  input  arraySize    sizeValue,
  input  logic        clearAll,
  input  elementIndex index,
  output arraySize    size,
  output logic        inBounds,
  output logic        full,
  output logic        empty
);

  arraySize sizes [`HEAP_ARRAYS];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else if (clearAll) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else if (sizeSet) begin
      sizes[array] <= sizeValue;                      // Zero on Alloc
    end
  end

  // Flags of the addressed array -------------------
  assign size     = sizes[array];
  assign inBounds = arraySize'(index) < size;
  assign full     = size == arraySize'(`HEAP_ARRAY_LENGTH);
  assign empty    = size == '0;

endmodule

//--- rtl/elementAlu.sv
//--------------------------------------------------
// Element arithmetic, wrapping at the data width, and
// the counter that Less accumulates over a scan.
//--------------------------------------------------
module elementAlu import heapStoragePkg::*, heapCommandPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  heapOp      aluOp,
  input  elementData element,
  input  elementData operand,
  input  logic       scanClear,
  input  logic       scanStep,
  output elementData aluResult
);

  arraySize lessCount;                                // Elements seen below operand

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      lessCount <= '0;
    end else if (scanClear) begin
      lessCount <= '0;
    end else if (scanStep && element < operand) begin
      lessCount <= lessCount + arraySize'(1);
    end
  end

  always_comb begin
    case (aluOp)
      opAdd:      aluResult = element + operand;      // Wraps at the data width
      opSubtract: aluResult = element - operand;
      opAnd:      aluResult = element & operand;
      opOr:       aluResult = element | operand;
      opXor:      aluResult = element ^ operand;
      opLess:     aluResult = elementData'(lessCount);
      default:    aluResult = element;
    endcase
  end

endmodule

//--- rtl/elementStore.sv
//--------------------------------------------------
// Element register file of all arrays. Asynchronous
// read at array and index, one write per clock edge.
//--------------------------------------------------
`include "heapMemory_settings.svh"

module elementStore import heapStoragePkg::*; (
  input  logic        clock,
  input  arrayNumber  array,
  input  elementIndex index,
  output elementData  element,
  input  logic        elementWrite,
  input  elementIndex writeIndex,
  input  elementData  writeValue
);

  elementData storage [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];

  assign element = storage[array][index];             // Read port

  // Write port shares the array of the read port
  always_ff @(posedge clock) begin
    if (elementWrite) storage[array][writeIndex] <= writeValue;
  end

endmodule

//--- rtl/heapCommandPkg.sv
//--------------------------------------------------
// Command side of the heap: bus fields, operation
// codes, error codes and the controller FSM states.
//--------------------------------------------------
`include "heapMemory_settings.svh"

package heapCommandPkg;

  // Operation code, then array number, then index
  typedef logic [`HEAP_OP_BITS+`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] busAddress;

  // Error code above the result word
  typedef logic [`HEAP_ERROR_BITS+`HEAP_DATA_BITS-1:0] busReadData;

  typedef enum logic [`HEAP_OP_BITS-1:0] {
    opClear    = 5'd1,                                // Free every array
    opWrite    = 5'd2,                                // Write one element
    opRead     = 5'd3,                                // Read one element
    opSize     = 5'd4,                                // Live elements of an array
    opLess     = 5'd8,                                // Count elements below operand
    opPush     = 5'd14,                               // Append at the top
    opPop      = 5'd15,                               // Remove from the top
    opAlloc    = 5'd18,                               // Hand out an array
    opFree     = 5'd19,                               // Give an array back
    opAdd      = 5'd20,
    opSubtract = 5'd22,
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } heapOp;

  typedef enum logic [`HEAP_ERROR_BITS-1:0] {
    errNone, errNotAllocated, errOutOfBounds, errArrayFull,
    errArrayEmpty, errNoFreeArray, errBadOperation
  } heapError;

  typedef enum logic [1:0] {stIdle, stLookup, stScan, stRespond} controllerState;

endpackage

//--- rtl/heapController.sv
//--------------------------------------------------
// Wishbone slave and command FSM of the heap. Latches
// one command, maps the storage flags to an error code
// and then writes back and acknowledges with the result.
//--------------------------------------------------
`include "heapMemory_settings.svh"

module heapController import heapStoragePkg::*, heapCommandPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  busAddress   adr,
  input  elementData  datWrite,
  output logic        ack,
  output busReadData  datRead,
  input  logic        allocated,
  input  arrayNumber  freeArray,
  input  logic        noFreeArray,
  input  arraySize    size,
  input  logic        inBounds,
  input  logic        full,
  input  logic        empty,
  input  elementData  element,
  input  elementData  aluResult,
  output arrayNumber  array,
  output elementIndex index,
  output elementData  operand,
  output logic        allocate,
  output logic        releaseArray,
  output logic        clearAll,
  output logic        sizeSet,
  output arraySize    sizeValue,
  output logic        elementWrite,
  output elementIndex writeIndex,
  output elementData  writeValue,
  output heapOp       aluOp,
  output logic        scanClear,
  output logic        scanStep,
  output elementIndex scanIndex
);

  controllerState state;
  heapOp       cmdOp;                                 // Latched command fields
  logic        cmdWrite;
  arrayNumber  cmdArray;
  elementIndex cmdIndex;
  elementData  cmdData;
  heapError    lookupError;                           // Decided during lookup
  heapError    errorCode;
  elementData  resultWord;
  elementIndex scanCount;
  elementIndex topIndex;                              // Last live element
  logic        arithmetic;
  logic        update;                                // Write-back cycle of a good command

  assign topIndex   = elementIndex'(size - arraySize'(1));
  assign arithmetic = cmdOp inside {opAdd, opSubtract, opAnd, opOr, opXor};
  assign update     = (state == stRespond) && (errorCode == errNone);

  // Error decode -------------------------------------
  always_comb begin
    lookupError = errNone;
    if (!cmdWrite) begin
      lookupError = errBadOperation;                  // Bus read cycles carry no command
    end else begin
      case (cmdOp)
        opClear: lookupError = errNone;
        opAlloc: if (noFreeArray) lookupError = errNoFreeArray;
        opWrite, opSize, opFree, opLess: if (!allocated) lookupError = errNotAllocated;
        opRead, opAdd, opSubtract, opAnd, opOr, opXor: begin
          if (!allocated) lookupError = errNotAllocated;
          else if (!inBounds) lookupError = errOutOfBounds;
        end
        opPush: begin
          if (!allocated) lookupError = errNotAllocated;
          else if (full) lookupError = errArrayFull;
        end
        opPop: begin
          if (!allocated) lookupError = errNotAllocated;
          else if (empty) lookupError = errArrayEmpty;
        end
        default: lookupError = errBadOperation;
      endcase
    end
  end

  // FSM ----------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: if (cyc && stb) state <= stLookup;
        stLookup: begin
          if (cmdOp == opLess && lookupError == errNone && !empty) state <= stScan;
          else state <= stRespond;
        end
        stScan: if (scanCount == topIndex) state <= stRespond;
        default: state <= stIdle;                     // Ack cycle ends here
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle && cyc && stb) begin
      cmdOp    <= heapOp'(adr[`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS +: `HEAP_OP_BITS]);
      cmdArray <= adr[`HEAP_INDEX_BITS +: `HEAP_ARRAY_BITS];
      cmdIndex <= adr[`HEAP_INDEX_BITS-1:0];
      cmdWrite <= we;
      cmdData  <= datWrite;
    end
    if (state == stLookup) begin
      errorCode <= lookupError;
      scanCount <= '0;
      case (cmdOp)
        opWrite, opPush: resultWord <= cmdData;
        opRead, opPop: resultWord <= element;
        opSize: resultWord <= elementData'(size);
        opAlloc: resultWord <= elementData'(freeArray);
        opAdd, opSubtract, opAnd, opOr, opXor: resultWord <= aluResult;
        default: resultWord <= '0;
      endcase
    end
    if (state == stScan) scanCount <= scanCount + elementIndex'(1);
  end

  // New size of the addressed array
  always_comb begin
    case (cmdOp)
      opWrite: sizeValue = inBounds ? size : arraySize'(cmdIndex) + arraySize'(1);
      opPush:  sizeValue = size + arraySize'(1);
      opPop:   sizeValue = size - arraySize'(1);
      default: sizeValue = '0;                        // Fresh array after Alloc
    endcase
  end

  assign ack     = state == stRespond;
  assign datRead = {errorCode, (errorCode != errNone) ? '0 :
                               (cmdOp == opLess) ? aluResult : resultWord};

  // Alloc writes back the size of the array it handed out
  assign array     = (state == stRespond && cmdOp == opAlloc) ? arrayNumber'(resultWord) : cmdArray;
  assign index     = cmdIndex;
  assign operand   = cmdData;
  assign aluOp     = cmdOp;
  assign scanIndex = (state == stScan) ? scanCount : (cmdOp == opPop) ? topIndex : cmdIndex;
  assign scanClear = state == stLookup;
  assign scanStep  = state == stScan;

  assign allocate     = update && cmdOp == opAlloc;
  assign releaseArray = update && cmdOp == opFree;
  assign clearAll     = update && cmdOp == opClear;
  assign sizeSet      = update && (cmdOp inside {opWrite, opPush, opPop, opAlloc});
  assign elementWrite = update && ((cmdOp inside {opWrite, opPush}) || arithmetic);
  assign writeIndex   = (cmdOp == opPush) ? elementIndex'(size) : cmdIndex;
  assign writeValue   = arithmetic ? resultWord : cmdData;

endmodule

//--- rtl/heapMemory.sv
//--------------------------------------------------
// Array heap top level. Joins the Wishbone controller
// to the allocator, size table, store and ALU.
//--------------------------------------------------
module heapMemory import heapStoragePkg::*, heapCommandPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  busAddress  adr,
  input  elementData datWrite,
  output logic       ack,
  output busReadData datRead
);

  // Storage answers --------------------------------
  logic        allocated, noFreeArray, inBounds, full, empty;
  arrayNumber  freeArray;
  arraySize    size;
  elementData  element, aluResult;

  // Controller requests ----------------------------
  arrayNumber  array;
  elementIndex index, writeIndex, scanIndex;
  elementData  operand, writeValue;
  logic        allocate, releaseArray, clearAll, sizeSet, elementWrite;
  logic        scanClear, scanStep;
  arraySize    sizeValue;
  heapOp       aluOp;

  heapController u_controller (.*);

  arrayAllocator u_allocator (
    .clock, .reset, .array, .allocate, .releaseArray, .clearAll,
    .allocated, .freeArray, .noFreeArray
  );

  arraySizeTable u_sizeTable (
    .clock, .reset, .array, .sizeSet, .sizeValue, .clearAll, .index,
    .size, .inBounds, .full, .empty
  );

  elementStore u_store (
    .clock, .array, .index(scanIndex), .element,       // Read pointer from the controller
    .elementWrite, .writeIndex, .writeValue
  );

  elementAlu u_alu (
    .clock, .reset, .aluOp, .element, .operand, .scanClear, .scanStep, .aluResult
  );

endmodule

//--- rtl/heapMemory_settings.svh
//--------------------------------------------------
// Geometry and bus widths of the array heap.
// Included by the packages and by every module that
// sizes its storage from these values.
//--------------------------------------------------
`ifndef HEAP_MEMORY_SETTINGS_SVH
`define HEAP_MEMORY_SETTINGS_SVH

// Storage geometry ---------------------------------
`define HEAP_ARRAY_BITS 3                             // Bits in an array number
`define HEAP_INDEX_BITS 3                             // Bits in an element index
`define HEAP_DATA_BITS 12                             // Width of one data word

// Bus fields ---------------------------------------
`define HEAP_OP_BITS 5                                // Operation code in the address
`define HEAP_ERROR_BITS 4                             // Error code in the read data

// Derived counts
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)           // Number of arrays
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)     // Elements per array

`endif

//--- rtl/heapStoragePkg.sv
//--------------------------------------------------
// Vector types of the heap storage: array numbers,
// element indexes, sizes and data words.
//--------------------------------------------------
`include "heapMemory_settings.svh"

package heapStoragePkg;

  // Which array a command addresses
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumber;

  // Position within one array
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex;

  // Live element count, one bit wider than an index
  typedef logic [`HEAP_INDEX_BITS:0] arraySize;

  // One stored word
  typedef logic [`HEAP_DATA_BITS-1:0] elementData;

endpackage

//--- run.sh
#!/bin/sh
# Builds the heap testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module heapTb \
  -Mdir obj_dir -o heapSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/heapSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+rtl
+incdir+bench
rtl/heapStoragePkg.sv
rtl/heapCommandPkg.sv
rtl/arrayAllocator.sv
rtl/arraySizeTable.sv
rtl/elementStore.sv
rtl/elementAlu.sv
rtl/heapController.sv
rtl/heapMemory.sv
bench/clockGen.sv
bench/heapTb.sv
